//--- project.f
hw/sx_pkg.sv
hw/sx_decode.sv
hw/sx_alu.sv
hw/sx_regfile.sv
hw/sx_core.sv
verification/sx_chk.sv
verification/sx_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= sx_tb
FILELIST  ?= project.f
LOG       ?= sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/sx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sx_tb
   import sx_pkg::*;
;

   logic            clk = 1'b0;
   logic            i_rst;
   logic [31:0]     i_instr;
   logic            i_instr_valid;
   logic [4:0]      i_dbg_addr;
   wire             o_instr_ready;
   wire             o_done;
   wire [XLEN-1:0]  o_dbg_data;

   logic [XLEN-1:0] model [32];
   logic [31:0]     rng = 32'd58;
   int              test_errs;
   int              n_pass;
   int              n_fail;

   sx_core u_dut (.*);

   always #2 clk = ~clk;  // 4 ns period.

   function automatic logic [31:0] xorshift32(logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic instr_u make_r(logic [4:0] op, logic [2:0] f3, logic [6:0] f7,
                                     logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
      instr_u w;
      w.r.funct7 = f7;
      w.r.rs2    = rs2;
      w.r.rs1    = rs1;
      w.r.funct3 = f3;
      w.r.rd     = rd;
      w.r.opcode = {op, 2'b11};
      return w;
   endfunction

   function automatic instr_u make_i(logic [4:0] op, logic [2:0] f3, logic [4:0] rd,
                                     logic [4:0] rs1, logic [11:0] imm);
      instr_u w;
      w.i.imm12  = imm;
      w.i.rs1    = rs1;
      w.i.funct3 = f3;
      w.i.rd     = rd;
      w.i.opcode = {op, 2'b11};
      return w;
   endfunction

   // expected rd value; unsupported encodings leave rd as it was.
   function automatic logic [XLEN-1:0] ref_result(instr_u w, logic [XLEN-1:0] m [32]);
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      logic            is_op;
      is_op = (w.r.opcode[6:2] == OP_OP);
      a = m[w.r.rs1];
      b = is_op ? m[w.r.rs2] : {{(XLEN-12){w.i.imm12[11]}}, w.i.imm12};
      if (w.r.opcode[6:2] == OP_LUI)
         return {w[31:12], 12'd0};
      if (!is_op && w.r.opcode[6:2] != OP_OPIMM)
         return m[w.r.rd];
      case (w.r.funct3)
         F3_ADD:  return (is_op && w.r.funct7[5]) ? a - b : a + b;
         F3_SLT:  return {31'd0, $signed(a) < $signed(b)};
         F3_SLTU: return {31'd0, a < b};
         F3_XOR:  return a ^ b;
         F3_OR:   return a | b;
         F3_AND:  return a & b;
         default: return m[w.r.rd];  // shifts are not implemented.
      endcase
   endfunction

   task automatic check_word(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
      if (exp !== act) begin
         $display("error %s: expected %h, actual %h", name, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_flag(string name, logic exp, logic act);
      if (exp !== act) begin
         $display("error %s: expected %b, actual %b", name, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_regs(string name);
      for (int k = 0; k < 32; k++) begin
         @(negedge clk);
         i_dbg_addr = k[4:0];
         #1;
         check_word($sformatf("%s x%0d", name, k), model[k], o_dbg_data);
      end
   endtask

   // ************************************************************
   // one instruction: handshake, wait for retire, compare rd
   // ************************************************************
   task automatic exec(string name, instr_u w);
      int t;
      @(negedge clk);
      i_instr       = w;
      i_instr_valid = 1'b1;
      t = 0;
      while (!o_instr_ready && t < 100) begin
         @(negedge clk);
         t++;
      end
      if (!o_instr_ready) begin
         $display("%s: timed out waiting for the DUT to accept the instruction", name);
         test_errs++;
      end
      @(negedge clk);
      i_instr_valid = 1'b0;
      t = 0;
      while (!o_done && t < 200) begin
         check_flag({name, " ready low in flight"}, 1'b0, o_instr_ready);
         @(negedge clk);
         t++;
      end
      if (!o_done) begin
         $display("%s: timed out waiting for the instruction to retire", name);
         test_errs++;
      end
      if (w.r.rd != 5'd0)
         model[w.r.rd] = ref_result(w, model);
      i_dbg_addr = w.r.rd;
      #1;
      check_word(name, model[w.r.rd], o_dbg_data);
   endtask

   task automatic finish_test(string name);
      $display("test %s: %s (%0d errors)", name, (test_errs == 0) ? "ok" : "failed", test_errs);
      if (test_errs == 0)
         n_pass++;
      else
         n_fail++;
      test_errs = 0;
   endtask

   initial begin
      logic [2:0] f3s [5];
      logic [4:0] rd;
      i_rst = 1'b1;
      i_instr = '0;
      i_instr_valid = 1'b0;
      i_dbg_addr = '0;
      test_errs = 0;
      n_pass = 0;
      n_fail = 0;
      for (int k = 0; k < 32; k++)
         model[k] = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;

      // ************************************************************
      check_flag("reset ready", 1'b1, o_instr_ready);
      check_flag("reset done", 1'b0, o_done);
      check_regs("reset");
      finish_test("reset");

      for (int k = 1; k < 8; k++) begin
         rng = xorshift32(rng);
         exec("addi seed", make_i(OP_OPIMM, F3_ADD, k[4:0], 5'd0, rng[11:0]));
      end
      f3s = '{F3_ADD, F3_ADD, F3_AND, F3_OR, F3_XOR};
      for (int k = 0; k < 15; k++) begin
         rng = xorshift32(rng);
         rd = 5'd1 + rng[3:0];
         exec("alu op", make_r(OP_OP, f3s[k % 5], (k % 5 == 1) ? 7'h20 : 7'h00, rd,
                               5'd1 + rng[6:4], 5'd1 + rng[9:7]));
      end
      exec("lui msb", make_i(OP_LUI, 3'd0, 5'd8, 5'd0, 12'h800));
      exec("add wrap", make_r(OP_OP, F3_ADD, 7'h00, 5'd9, 5'd8, 5'd8));
      exec("sub wrap", make_r(OP_OP, F3_ADD, 7'h20, 5'd10, 5'd0, 5'd8));
      finish_test("arith");

      exec("addi pos", make_i(OP_OPIMM, F3_ADD, 5'd12, 5'd0, 12'd5));
      exec("addi neg", make_i(OP_OPIMM, F3_ADD, 5'd13, 5'd0, -12'sd5));
      exec("addi eq", make_i(OP_OPIMM, F3_ADD, 5'd14, 5'd0, 12'd5));
      exec("sign only", make_i(OP_OPIMM, F3_ADD, 5'd19, 5'd8, 12'd5));
      exec("slt neg", make_r(OP_OP, F3_SLT, 7'h00, 5'd15, 5'd13, 5'd12));
      exec("sltu neg", make_r(OP_OP, F3_SLTU, 7'h00, 5'd16, 5'd13, 5'd12));
      exec("slt eq", make_r(OP_OP, F3_SLT, 7'h00, 5'd17, 5'd12, 5'd14));
      exec("slt sign", make_r(OP_OP, F3_SLT, 7'h00, 5'd18, 5'd19, 5'd12));
      exec("sltu sign", make_r(OP_OP, F3_SLTU, 7'h00, 5'd20, 5'd19, 5'd12));
      exec("slti", make_i(OP_OPIMM, F3_SLT, 5'd21, 5'd13, -12'sd4));
      exec("sltiu max", make_i(OP_OPIMM, F3_SLTU, 5'd22, 5'd12, 12'hfff));
      exec("sltiu eq", make_i(OP_OPIMM, F3_SLTU, 5'd23, 5'd12, 12'd5));
      for (int k = 0; k < 6; k++) begin
         rng = xorshift32(rng);
         exec("slt rand", make_r(OP_OP, rng[0] ? F3_SLTU : F3_SLT, 7'h00, 5'd24,
                                 5'd1 + rng[3:1], 5'd1 + rng[6:4]));
      end
      finish_test("compare");

      rng = xorshift32(rng);
      exec("lui rand", make_i(OP_LUI, rng[2:0], 5'd25, rng[7:3], rng[19:8]));
      exec("lui x0", make_i(OP_LUI, 3'd0, 5'd0, 5'd3, 12'habc));
      exec("addi x0", make_i(OP_OPIMM, F3_ADD, 5'd0, 5'd0, 12'h123));
      finish_test("lui");

      exec("load opcode", make_i(5'b00000, 3'd2, 5'd5, 5'd1, 12'h010));
      exec("slli", make_i(OP_OPIMM, 3'b001, 5'd6, 5'd1, 12'd3));
      check_regs("unsupported");
      finish_test("unsupported");

      $display("tests passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/sx_chk.sv
`timescale 1ns/1ps
`default_nettype none

module sx_chk (
   input wire clk,
   input wire i_rst,
   input wire i_done,
   input wire i_rf_rd_en,
   input wire i_rf_req,
   input wire i_rf_ready
);

   a_done_pulse : assert property (@(posedge clk) disable iff (i_rst) i_done |=> !i_done)
      else $error("o_done stayed high for more than one cycle");

   // writes open with the final pass and close as the instruction retires.
   a_wr_in_run : assert property (@(posedge clk) disable iff (i_rst)
                                  $rose(i_rf_rd_en) |-> ##32 (i_done && !i_rf_rd_en))
      else $error("register write enable did not span exactly the final pass");

   a_req_ready : assert property (@(posedge clk) disable iff (i_rst) i_rf_req |=> i_rf_ready)
      else $error("register file did not answer a request on the next cycle");

endmodule

bind sx_decode sx_chk u_chk (
   .clk        (clk),
   .i_rst      (i_rst),
   .i_done     (o_done),
   .i_rf_rd_en (o_rf_rd_en),
   .i_rf_req   (o_rf_req),
   .i_rf_ready (i_rf_ready)
);

`default_nettype wire

//--- hw/sx_core.sv
`timescale 1ns/1ps
`default_nettype none

module sx_core
   import sx_pkg::*;
(
   input  wire             clk,
   input  wire             i_rst,
   input  wire [31:0]      i_instr,
   input  wire             i_instr_valid,
   output logic            o_instr_ready,
   output logic            o_done,
   input  wire [4:0]       i_dbg_addr,
   output logic [XLEN-1:0] o_dbg_data
);

   wire       rf_req;
   wire       rf_ready;
   wire [4:0] rs1_addr;
   wire [4:0] rs2_addr;
   wire [4:0] rd_addr;
   wire [4:0] cnt;
   wire       rf_rs_en;
   wire       rf_rd_en;
   wire       alu_en;
   wire       alu_init;
   wire       alu_sub;
   wire [1:0] alu_bool_op;
   wire       alu_cmp_uns;
   wire [1:0] alu_rd_sel;
   wire       op_b_source;
   wire       imm_bit;
   wire       rs1_bit;
   wire       rs2_bit;
   wire       rd_bit;

   sx_decode u_decode (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_instr       (i_instr),
      .i_instr_valid (i_instr_valid),
      .o_instr_ready (o_instr_ready),
      .o_done        (o_done),
      .i_rf_ready    (rf_ready),
      .o_rf_req      (rf_req),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .o_rd_addr     (rd_addr),
      .o_cnt         (cnt),
      .o_rf_rs_en    (rf_rs_en),
      .o_rf_rd_en    (rf_rd_en),
      .o_alu_en      (alu_en),
      .o_alu_init    (alu_init),
      .o_alu_sub     (alu_sub),
      .o_alu_bool_op (alu_bool_op),
      .o_alu_cmp_uns (alu_cmp_uns),
      .o_alu_rd_sel  (alu_rd_sel),
      .o_op_b_source (op_b_source),
      .o_imm         (imm_bit)
   );

   sx_alu u_alu (
      .clk           (clk),
      .i_en          (alu_en),
      .i_init        (alu_init),
      .i_sub         (alu_sub),
      .i_bool_op     (alu_bool_op),
      .i_cmp_uns     (alu_cmp_uns),
      .i_rd_sel      (alu_rd_sel),
      .i_op_b_source (op_b_source),
      .i_rs1         (rs1_bit),
      .i_rs2         (rs2_bit),
      .i_imm         (imm_bit),
      .o_rd          (rd_bit)
   );

   sx_regfile u_regfile (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_req      (rf_req),
      .o_ready    (rf_ready),
      .i_cnt      (cnt),
      .i_rs_en    (rf_rs_en),
      .i_rd_en    (rf_rd_en),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd       (rd_bit),
      .o_rs1      (rs1_bit),
      .o_rs2      (rs2_bit),
      .i_dbg_addr (i_dbg_addr),
      .o_dbg_data (o_dbg_data)
   );

endmodule

`default_nettype wire

//--- hw/sx_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module sx_regfile
   import sx_pkg::*;
(
   input  wire             clk,
   input  wire             i_rst,
   input  wire             i_req,
   output logic            o_ready,
   input  wire [4:0]       i_cnt,
   input  wire             i_rs_en,
   input  wire             i_rd_en,
   input  wire [4:0]       i_rs1_addr,
   input  wire [4:0]       i_rs2_addr,
   input  wire [4:0]       i_rd_addr,
   input  wire             i_rd,
   output logic            o_rs1,
   output logic            o_rs2,
   input  wire [4:0]       i_dbg_addr,
   output logic [XLEN-1:0] o_dbg_data
);

   logic [XLEN-1:0] regs [32];

   wire [XLEN-1:0] rs1_word = regs[i_rs1_addr];
   wire [XLEN-1:0] rs2_word = regs[i_rs2_addr];

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_ready <= 1'b0;
         for (int k = 0; k < 32; k++)
            regs[k] <= '0;  // all registers read zero out of reset.
      end else begin
         o_ready <= i_req;
         if (i_rd_en)
            regs[i_rd_addr][i_cnt] <= i_rd;  // one bit of rd per cycle.
      end
   end

   // serial source bits, x0 forced to zero.
   assign o_rs1 = i_rs_en & (i_rs1_addr != 5'd0) & rs1_word[i_cnt];
   assign o_rs2 = i_rs_en & (i_rs2_addr != 5'd0) & rs2_word[i_cnt];

   assign o_dbg_data = (i_dbg_addr == 5'd0) ? '0 : regs[i_dbg_addr];

endmodule

`default_nettype wire

//--- hw/sx_alu.sv
`timescale 1ns/1ps
`default_nettype none

module sx_alu
   import sx_pkg::*;
(
   input  wire       clk,
   input  wire       i_en,
   input  wire       i_init,
   input  wire       i_sub,
   input  wire [1:0] i_bool_op,
   input  wire       i_cmp_uns,
   input  wire [1:0] i_rd_sel,
   input  wire       i_op_b_source,
   input  wire       i_rs1,
   input  wire       i_rs2,
   input  wire       i_imm,
   output logic      o_rd
);

   logic carry_r;
   logic en_r;
   logic init_r;
   logic lt_r;
   logic bool_bit;

   // bit 0 of a pass: first enabled cycle, or first cycle after the compare pass.
   wire first_bit = !en_r | (init_r & !i_init);

   wire op_b  = i_op_b_source ? i_rs2 : i_imm;
   wire b_eff = op_b ^ i_sub;
   wire c_in  = first_bit ? i_sub : carry_r;  // +1 of the two's complement.
   wire sum   = i_rs1 ^ b_eff ^ c_in;
   wire c_out = (i_rs1 & b_eff) | (c_in & (i_rs1 ^ b_eff));

   wire lt_s = (i_rs1 ^ op_b) ? i_rs1 : sum;  // signs differ: a negative means less.
   wire lt_u = !c_out;                        // borrow out of the msb.

   always_comb begin
      case (i_bool_op)
         2'b10:   bool_bit = i_rs1 | op_b;
         2'b11:   bool_bit = i_rs1 & op_b;
         default: bool_bit = i_rs1 ^ op_b;
      endcase
   end

   always_ff @(posedge clk) begin
      en_r   <= i_en;
      init_r <= i_init;
      if (i_en)
         carry_r <= c_out;
      // the last bit of the pass leaves the final flag.
      if (i_en & i_init)
         lt_r <= i_cmp_uns ? lt_u : lt_s;
   end

   always_comb begin
      case (i_rd_sel)
         ALU_RESULT_ADD:  o_rd = sum;
         ALU_RESULT_BOOL: o_rd = bool_bit;
         ALU_RESULT_LT:   o_rd = lt_r & first_bit & !i_init;
         ALU_RESULT_IMM:  o_rd = i_imm;
         default:         o_rd = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- hw/sx_decode.sv
`timescale 1ns/1ps
`default_nettype none

module sx_decode
   import sx_pkg::*;
(
   input  wire         clk,
   input  wire         i_rst,
   input  wire instr_u i_instr,
   input  wire         i_instr_valid,
   output logic        o_instr_ready,
   output logic        o_done,
   input  wire         i_rf_ready,
   output logic        o_rf_req,
   output logic [4:0]  o_rs1_addr,
   output logic [4:0]  o_rs2_addr,
   output logic [4:0]  o_rd_addr,
   output logic [4:0]  o_cnt,
   output logic        o_rf_rs_en,
   output logic        o_rf_rd_en,
   output logic        o_alu_en,
   output logic        o_alu_init,
   output logic        o_alu_sub,
   output logic [1:0]  o_alu_bool_op,
   output logic        o_alu_cmp_uns,
   output logic [1:0]  o_alu_rd_sel,
   output logic        o_op_b_source,
   output logic        o_imm
);

   logic [1:0]      state;
   logic [4:0]      cnt;
   logic            pend;        // accepted, not yet started.
   logic            stage_done;  // compare pass finished.

   logic [4:0]      opcode;
   logic [2:0]      funct3;
   logic            bit30;
   logic [XLEN-1:0] imm;

   wire accept   = i_instr_valid & o_instr_ready;
   wire cnt_en   = (state != ST_IDLE);
   wire cnt_done = (cnt == 5'd31);

   // ************************************************************
   // field decode
   // ************************************************************
   wire is_op     = (opcode == OP_OP);
   wire is_opimm  = (opcode == OP_OPIMM);
   wire is_lui    = (opcode == OP_LUI);
   wire f3_ok     = (funct3[1:0] != 2'b01);  // 001 and 101 are shifts.
   wire slt_op    = (is_op | is_opimm) & ((funct3 == F3_SLT) | (funct3 == F3_SLTU));
   wire supported = ((is_op | is_opimm) & f3_ok) | is_lui;

   // ************************************************************
   // instruction latch and immediate
   // ************************************************************
   always_ff @(posedge clk) begin
      if (accept) begin
         opcode     <= i_instr.i.opcode[6:2];
         funct3     <= i_instr.i.funct3;
         bit30      <= i_instr.r.funct7[5];
         o_rs1_addr <= i_instr.i.rs1;
         o_rs2_addr <= i_instr.r.rs2;
         o_rd_addr  <= i_instr.i.rd;
         if (i_instr.i.opcode[6:2] == OP_LUI)
            imm <= {i_instr.i.imm12, i_instr.i.rs1, i_instr.i.funct3, 12'd0};
         else
            imm <= {{(XLEN-12){i_instr.i.imm12[11]}}, i_instr.i.imm12};
      end else if (cnt_en) begin
         imm <= {imm[0], imm[XLEN-1:1]};  // lsb first, back in place after a pass.
      end
   end

   // ************************************************************
   // state machine and bit counter
   // ************************************************************
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state      <= ST_IDLE;
         cnt        <= 5'd0;
         pend       <= 1'b0;
         stage_done <= 1'b0;
         o_rf_req   <= 1'b0;
         o_done     <= 1'b0;
      end else begin
         o_rf_req <= accept;
         o_done   <= (state == ST_RUN) & cnt_done;

         if (cnt_en)
            cnt <= cnt + 5'd1;  // wraps to 0 at the end of each pass.

         if (accept) begin
            pend       <= 1'b1;
            stage_done <= 1'b0;
         end

         case (state)
            ST_IDLE: begin
               if (i_rf_ready) begin
                  pend  <= 1'b0;
                  state <= (slt_op & !stage_done) ? ST_INIT : ST_RUN;
               end
            end
            ST_INIT: begin
               if (cnt_done) begin
                  stage_done <= 1'b1;
                  state      <= ST_RUN;
               end
            end
            ST_RUN: begin
               if (cnt_done)
                  state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // ************************************************************
   // control outputs
   // ************************************************************
   assign o_instr_ready = (state == ST_IDLE) & !pend;
   assign o_cnt         = cnt;
   assign o_rf_rs_en    = cnt_en;
   assign o_alu_en      = cnt_en;
   assign o_alu_init    = (state == ST_INIT);

   // a compare result is only written once its pass is complete.
   assign o_rf_rd_en = (state == ST_RUN) & supported & (o_rd_addr != 5'd0) &
                       (stage_done | !slt_op);

   assign o_alu_sub     = (is_op & (funct3 == F3_ADD) & bit30) | slt_op;
   assign o_alu_bool_op = funct3[1:0];
   assign o_alu_cmp_uns = (funct3 == F3_SLTU);
   assign o_op_b_source = is_op;  // rs2 for OP, immediate otherwise.
   assign o_imm         = imm[0];

   always_comb begin
      case (funct3)
         F3_SLT, F3_SLTU:       o_alu_rd_sel = ALU_RESULT_LT;
         F3_XOR, F3_OR, F3_AND: o_alu_rd_sel = ALU_RESULT_BOOL;
         default:               o_alu_rd_sel = ALU_RESULT_ADD;
      endcase
      if (is_lui)
         o_alu_rd_sel = ALU_RESULT_IMM;
   end

endmodule

`default_nettype wire

//--- hw/sx_pkg.sv
`default_nettype none

package sx_pkg;

   // ************************************************************
   // datapath width
   // ************************************************************
   localparam int XLEN = 32;

   // ************************************************************
   // major opcodes, instruction bits 6:2
   // ************************************************************
   localparam logic [4:0] OP_OP    = 5'b01100;
   localparam logic [4:0] OP_OPIMM = 5'b00100;
   localparam logic [4:0] OP_LUI   = 5'b01101;

   // funct3 codes shared by OP and OP-IMM.
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   // ************************************************************
   // alu result select and decoder states
   // ************************************************************
   localparam logic [1:0] ALU_RESULT_ADD  = 2'd0;
   localparam logic [1:0] ALU_RESULT_BOOL = 2'd1;
   localparam logic [1:0] ALU_RESULT_LT   = 2'd2;
   localparam logic [1:0] ALU_RESULT_IMM  = 2'd3;

   localparam logic [1:0] ST_IDLE = 2'd0;   // waiting, or handshaking with the regfile.
   localparam logic [1:0] ST_INIT = 2'd1;   // compare pass.
   localparam logic [1:0] ST_RUN  = 2'd2;   // write pass.

   // one instruction word, seen as R-format or as I-format.
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm12;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
   } instr_u;

endpackage

`default_nettype wire
